//--- dmc_settings.svh
// DMC channel settings
`ifndef DMC_SETTINGS_SVH
`define DMC_SETTINGS_SVH

// Datapath widths
`define DMC_ADDR_W     16     // Memory address
`define DMC_LEN_W      12     // Bytes remaining
`define DMC_LEVEL_W    7      // DAC level
`define DMC_PERIOD_W   9      // Rate timer

// Sample address rules
`define DMC_ADDR_BASE  16'hC000   // Start of sample area
`define DMC_ADDR_STEP  64         // Per unit of the address byte
`define DMC_ADDR_WRAP  16'h8000   // Address that follows FFFF

// Sample length rule
`define DMC_LEN_STEP   16         // Per unit of the length byte plus one

`endif

//--- dmc_pkg.sv
// DMC channel types
`include "dmc_settings.svh"

package dmc_pkg;

	// Channel register offsets
	typedef enum logic [2:0] {
		off_ctrl   = 3'd0,   // Rate, loop, irq enable
		off_level  = 3'd1,   // Direct level load
		off_addr   = 3'd2,   // Sample start address
		off_len    = 3'd3,   // Sample length
		off_status = 3'd5    // Enable and irq acknowledge
	} dmc_reg_e;

	typedef logic [3:0]                 rate_idx_t;
	typedef logic [`DMC_PERIOD_W-1:0]   period_t;
	typedef logic [`DMC_ADDR_W-1:0]     addr_t;
	typedef logic [`DMC_LEN_W-1:0]      len_t;
	typedef logic [`DMC_LEVEL_W-1:0]    level_t;
	typedef logic [7:0]                 byte_t;

	// Bit periods in aclk cycles per rate select
	localparam period_t dmc_period_table [16] = '{
		214, 190, 170, 160,
		143, 127, 113, 107,
		95,  80,  71,  64,
		53,  42,  36,  27
	};

endpackage

//--- dmc_reg_if.sv
// DMC configuration interface
interface dmc_reg_if;
	import dmc_pkg::*;

	rate_idx_t rate_idx;     // Bit rate select
	logic      loop_en;      // Restart at end of sample
	logic      irq_en;       // End of sample raises irq
	addr_t     start_addr;
	len_t      start_len;
	logic      enable_wr;    // Status write strobe
	logic      enable_val;
	logic      irq_clr;
	logic      level_wr;     // Level write strobe
	level_t    level_val;

	modport regs (
		output rate_idx, loop_en, irq_en, start_addr, start_len,
		output enable_wr, enable_val, irq_clr, level_wr, level_val
	);

	modport fetch (
		input loop_en, irq_en, start_addr, start_len,
		input enable_wr, enable_val, irq_clr
	);

	// Output unit only needs the rate and the level override
	modport out (
		input rate_idx, level_wr, level_val
	);

endinterface

//--- dmc_sample_if.sv
// DMC sample byte interface
interface dmc_sample_if;
	import dmc_pkg::*;

	logic  fill;        // One cycle, from the fetcher
	byte_t fill_data;
	logic  full;        // Buffer holds a byte
	byte_t held;
	logic  take;        // One cycle, from the output unit

	modport fetch (
		output fill, fill_data,
		input  full
	);

	modport buffer (
		input  fill, fill_data, take,
		output full, held
	);

	modport out (
		input  full, held,
		output take
	);

endinterface

//--- dmc_regs.sv
// DMC register block
`include "dmc_settings.svh"

module dmc_regs (
	input  logic              aclk,
	input  logic              rst,
	input  logic              reg_wr,
	input  dmc_pkg::dmc_reg_e reg_addr,
	input  dmc_pkg::byte_t    reg_wdata,
	dmc_reg_if.regs           cfg
);
	import dmc_pkg::*;

	rate_idx_t rate_q;
	logic      loop_q;
	logic      irq_en_q;
	byte_t     addr_q;     // Address byte as written
	byte_t     len_q;      // Length byte as written
	logic      wr_ctrl;
	logic      wr_level;
	logic      wr_addr;
	logic      wr_len;
	logic      wr_status;

	assign wr_ctrl   = reg_wr && (reg_addr == off_ctrl);
	assign wr_level  = reg_wr && (reg_addr == off_level);
	assign wr_addr   = reg_wr && (reg_addr == off_addr);
	assign wr_len    = reg_wr && (reg_addr == off_len);
	assign wr_status = reg_wr && (reg_addr == off_status);

	always_ff @(posedge aclk) begin
		if (rst) begin
			rate_q   <= '0;
			loop_q   <= 1'b0;
			irq_en_q <= 1'b0;
			addr_q   <= '0;
			len_q    <= '0;
		end else begin
			if (wr_ctrl) begin
				rate_q   <= reg_wdata[3:0];
				loop_q   <= reg_wdata[6];
				irq_en_q <= reg_wdata[7];
			end
			if (wr_addr)
				addr_q <= reg_wdata;
			if (wr_len)
				len_q <= reg_wdata;
		end
	end

	assign cfg.rate_idx   = rate_q;
	assign cfg.loop_en    = loop_q;
	assign cfg.irq_en     = irq_en_q;
	assign cfg.start_addr = addr_t'(`DMC_ADDR_BASE) + addr_t'(addr_q) * addr_t'(`DMC_ADDR_STEP);
	assign cfg.start_len  = len_t'(len_q) * len_t'(`DMC_LEN_STEP) + len_t'(1);

	// Strobes act on the same edge in the fetcher and output unit
	assign cfg.enable_wr  = wr_status;
	assign cfg.enable_val = reg_wdata[4];
	assign cfg.irq_clr    = wr_status || (wr_ctrl && !reg_wdata[7]);   // Ack or irq disabled
	assign cfg.level_wr   = wr_level;
	assign cfg.level_val  = reg_wdata[6:0];

endmodule

//--- dmc_fetch.sv
// DMC sample fetcher
`include "dmc_settings.svh"

module dmc_fetch (
	input  logic            aclk,
	input  logic            rst,
	dmc_reg_if.fetch        cfg,
	dmc_sample_if.fetch     smp,
	output logic            dma_req,
	output dmc_pkg::addr_t  dma_addr,
	input  logic            dma_ack,
	input  dmc_pkg::byte_t  dma_rdata,
	output logic            irq,
	output logic            dmc_active
);
	import dmc_pkg::*;

	addr_t cur_addr;       // Next byte to read
	addr_t req_addr;       // Frozen while a request is open
	len_t  count;          // Bytes remaining
	logic  req_q;
	logic  irq_q;
	logic  fill_q;
	byte_t fill_data_q;
	logic  got_byte;
	logic  stop;
	logic  start;
	logic  step;
	logic  last;
	addr_t next_addr;

	assign got_byte  = req_q && dma_ack;
	assign stop      = cfg.enable_wr && !cfg.enable_val;
	assign start     = cfg.enable_wr && cfg.enable_val && (count == '0);   // Restart only when idle
	assign step      = got_byte && (count != '0) && !stop;
	assign last      = step && (count == len_t'(1));
	assign next_addr = (cur_addr == '1) ? addr_t'(`DMC_ADDR_WRAP) : cur_addr + addr_t'(1);

	// A new request waits until the last byte has landed in the buffer
	always_ff @(posedge aclk) begin
		if (rst)
			req_q <= 1'b0;
		else if (got_byte)
			req_q <= 1'b0;
		else if (!req_q && (count != '0) && !smp.full && !fill_q)
			req_q <= 1'b1;
	end

	always_ff @(posedge aclk) begin
		if (!req_q)
			req_addr <= cur_addr;   // Captured on the edge that raises the request
	end

	always_ff @(posedge aclk) begin
		if (rst) begin
			cur_addr <= '0;
			count    <= '0;
		end else if (stop) begin
			count <= '0;
		end else if (start) begin
			cur_addr <= cfg.start_addr;
			count    <= cfg.start_len;
		end else if (last && cfg.loop_en) begin
			cur_addr <= cfg.start_addr;   // Loop back to the sample start
			count    <= cfg.start_len;
		end else if (step) begin
			cur_addr <= next_addr;
			count    <= count - len_t'(1);
		end
	end

	always_ff @(posedge aclk) begin
		if (rst)
			irq_q <= 1'b0;
		else if (cfg.irq_clr)
			irq_q <= 1'b0;
		else if (last && !cfg.loop_en && cfg.irq_en)
			irq_q <= 1'b1;
	end

	always_ff @(posedge aclk) begin
		if (rst)
			fill_q <= 1'b0;
		else
			fill_q <= got_byte;   // Fill one cycle after the ack
	end

	always_ff @(posedge aclk) begin
		if (got_byte)
			fill_data_q <= dma_rdata;
	end

	assign smp.fill      = fill_q;
	assign smp.fill_data = fill_data_q;
	assign dma_req       = req_q;
	assign dma_addr      = req_addr;
	assign irq           = irq_q;
	assign dmc_active    = (count != '0);

endmodule

//--- dmc_sample_buffer.sv
// DMC one-byte sample buffer
module dmc_sample_buffer (
	input  logic          aclk,
	input  logic          rst,
	dmc_sample_if.buffer  smp
);

	logic load;

	// Fill is refused while full, so a take in that cycle wins
	assign load = smp.fill && !smp.full;

	always_ff @(posedge aclk) begin
		if (rst)
			smp.full <= 1'b0;
		else if (load)
			smp.full <= 1'b1;
		else if (smp.take)
			smp.full <= 1'b0;   // Byte moved into the shifter
	end

	always_ff @(posedge aclk) begin
		if (load)
			smp.held <= smp.fill_data;
	end

endmodule

//--- dmc_output.sv
// DMC output unit
module dmc_output (
	input  logic            aclk,
	input  logic            rst,
	dmc_reg_if.out          cfg,
	dmc_sample_if.out       smp,
	output dmc_pkg::level_t dmc_out
);
	import dmc_pkg::*;

	period_t    timer;        // Cycles left in the current bit
	logic       tick;
	logic [2:0] bit_cnt;
	byte_t      shifter;
	logic       silent;       // No byte for this round of 8 bits
	level_t     level;
	logic       byte_end;
	logic       do_step;

	assign tick     = (timer == '0);
	assign byte_end = tick && (bit_cnt == 3'd7);
	assign do_step  = tick && !silent;
	assign smp.take = byte_end && smp.full;

	always_ff @(posedge aclk) begin
		if (rst)
			timer <= '0;
		else if (tick)
			timer <= dmc_period_table[cfg.rate_idx] - period_t'(1);
		else
			timer <= timer - period_t'(1);
	end

	always_ff @(posedge aclk) begin
		if (rst) begin
			bit_cnt <= '0;
			silent  <= 1'b1;
		end else if (tick) begin
			bit_cnt <= bit_cnt + 3'd1;   // Wraps after the eighth bit
			if (byte_end)
				silent <= !smp.full;
		end
	end

	always_ff @(posedge aclk) begin
		if (smp.take)
			shifter <= smp.held;
		else if (tick)
			shifter <= {1'b0, shifter[7:1]};   // LSB first
	end

	// Delta counter clamped so a step never wraps
	always_ff @(posedge aclk) begin
		if (rst) begin
			level <= '0;
		end else if (cfg.level_wr) begin
			level <= cfg.level_val;
		end else if (do_step) begin
			if (shifter[0]) begin
				if (level <= level_t'(125))
					level <= level + level_t'(2);
			end else if (level >= level_t'(2)) begin
				level <= level - level_t'(2);
			end
		end
	end

	assign dmc_out = level;

endmodule

//--- dmc_channel.sv
// DMC sample channel top
module dmc_channel (
	input  logic              aclk,
	input  logic              rst,
	input  logic              reg_wr,       // One-cycle write strobe
	input  dmc_pkg::dmc_reg_e reg_addr,
	input  dmc_pkg::byte_t    reg_wdata,
	output logic              dma_req,      // Held until dma_ack
	output dmc_pkg::addr_t    dma_addr,
	input  logic              dma_ack,
	input  dmc_pkg::byte_t    dma_rdata,    // Valid with dma_ack
	output dmc_pkg::level_t   dmc_out,
	output logic              irq,
	output logic              dmc_active
);

	dmc_reg_if    cfg_if ();
	dmc_sample_if smp_if ();

	dmc_regs u_regs (
		.aclk      (aclk),
		.rst       (rst),
		.reg_wr    (reg_wr),
		.reg_addr  (reg_addr),
		.reg_wdata (reg_wdata),
		.cfg       (cfg_if.regs)
	);

	dmc_fetch u_fetch (
		.aclk       (aclk),
		.rst        (rst),
		.cfg        (cfg_if.fetch),
		.smp        (smp_if.fetch),
		.dma_req    (dma_req),
		.dma_addr   (dma_addr),
		.dma_ack    (dma_ack),
		.dma_rdata  (dma_rdata),
		.irq        (irq),
		.dmc_active (dmc_active)
	);

	dmc_sample_buffer u_buffer (
		.aclk (aclk),
		.rst  (rst),
		.smp  (smp_if.buffer)
	);

	dmc_output u_output (
		.aclk    (aclk),
		.rst     (rst),
		.cfg     (cfg_if.out),
		.smp     (smp_if.out),
		.dmc_out (dmc_out)
	);

endmodule

//--- tb_dmc_channel.sv
// DMC channel testbench
`include "dmc_settings.svh"

module tb_dmc_channel;
	timeunit 1ns;
	timeprecision 1ps;
	import dmc_pkg::*;

	localparam int test_bytes = 17 + 65 + 40 + 5 + 4 * 3;   // Fetched bytes plus drain time
	localparam int wd_cycles  = test_bytes * 8 * 214 + 5000;
	localparam int bit_period [16] = '{
		214, 190, 170, 160, 143, 127, 113, 107,
		95, 80, 71, 64, 53, 42, 36, 27
	};

	logic     aclk;
	logic     rst;
	logic     reg_wr;
	dmc_reg_e reg_addr;
	byte_t    reg_wdata;
	logic     dma_req;
	addr_t    dma_addr;
	logic     dma_ack;
	byte_t    dma_rdata;
	level_t   dmc_out;
	logic     irq;
	logic     dmc_active;

	logic [31:0] lfsr = 32'h1987_fff7;
	string       cur_test = "reset";
	addr_t       exp_addr;             // Model of the fetch address
	len_t        exp_count;
	addr_t       loop_addr;
	len_t        loop_len;
	logic        exp_loop = 1'b0;
	int          model_level = 0;
	int          fetches = 0;
	level_t      exp_q [$];            // Predicted dmc_out changes
	bit          step_q [$];           // 1 for a bit step, 0 for a level write
	int          cyc = 0;
	int          last_step_cyc = -1;
	int          space_period = 214;

	dmc_channel i_dut (.*);

	initial begin
		aclk = 1'b0;
		forever #4 aclk = ~aclk;
	end

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	// Runs of 16 bytes mostly ones or mostly zeros
	function automatic byte_t mem_byte(input addr_t a);
		return (a[4] ? 8'hFF : 8'h00) ^ (a[7:0] & 8'h41) ^ {4'b0000, ^a, 3'b000};
	endfunction

	function automatic void play_byte(input byte_t b);
		for (int i = 0; i < 8; i++) begin
			if ((b[i] && model_level <= 125) || (!b[i] && model_level >= 2)) begin
				model_level += b[i] ? 2 : -2;
				exp_q.push_back(level_t'(model_level));
				step_q.push_back(1'b1);
			end
		end
	endfunction

	task automatic report_fail(input string msg);
		$display("%s", msg);
		$display("ERRORS FOUND");
		$fatal(1, "Simulation stopped");
	endtask

	task automatic check_addr(input string name, input addr_t exp, input addr_t act);
		if (act !== exp)
			report_fail($sformatf("FAIL %s expected %h actual %h", name, exp, act));
	endtask

	task automatic check_level(input string name, input level_t exp, input level_t act);
		if (act !== exp)
			report_fail($sformatf("FAIL %s expected %0d actual %0d", name, exp, act));
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp)
			report_fail($sformatf("FAIL %s expected %b actual %b", name, exp, act));
	endtask

	task automatic check_len(input string name, input len_t exp, input len_t act);
		if (act !== exp)
			report_fail($sformatf("FAIL %s expected %0d actual %0d", name, exp, act));
	endtask

	task automatic write_reg(input dmc_reg_e a, input byte_t d);
		@(posedge aclk);
		reg_wr    <= 1'b1;
		reg_addr  <= a;
		reg_wdata <= d;
		@(posedge aclk);
		reg_wr <= 1'b0;
	endtask

	task automatic start_sample(input string name, input rate_idx_t rate, input logic loop,
		input logic irq_on, input byte_t a, input byte_t l);
		cur_test      = name;
		space_period  = bit_period[rate];
		last_step_cyc = -1;
		write_reg(off_ctrl, {irq_on, loop, 2'b00, rate});
		write_reg(off_addr, a);
		write_reg(off_len, l);
		loop_addr = addr_t'(`DMC_ADDR_BASE + a * `DMC_ADDR_STEP);
		loop_len  = len_t'(l * `DMC_LEN_STEP + 1);
		exp_addr  = loop_addr;
		exp_count = loop_len;
		exp_loop  = loop;
		fetches   = 0;
		write_reg(off_status, 8'h10);   // Enable
	endtask

	// Bytes still in the buffer and shifter play out meanwhile
	task automatic drain(input string name, input logic irq_exp);
		repeat (18 * space_period) begin
			@(posedge aclk);
			check_bit({name, " dma_req idle"}, 1'b0, dma_req);
			check_bit({name, " irq"}, irq_exp, irq);
		end
		if (exp_q.size() != 0)
			report_fail($sformatf("%s: %0d level changes never reached dmc_out", name,
				exp_q.size()));
	endtask

	task automatic run_sample(input string name, input rate_idx_t rate, input logic irq_on,
		input byte_t a, input byte_t l);
		start_sample(name, rate, 1'b0, irq_on, a, l);
		do begin
			@(posedge aclk);
			if (dmc_active)
				check_bit({name, " irq before end"}, 1'b0, irq);
		end while (dmc_active);
		check_len({name, " fetch count"}, len_t'(l * `DMC_LEN_STEP + 1), len_t'(fetches));
		check_bit({name, " irq at end"}, irq_on, irq);
		drain(name, irq_on);
		write_reg(off_status, 8'h00);   // Acknowledge
		@(posedge aclk);
		check_bit({name, " irq cleared"}, 1'b0, irq);
	endtask

	task automatic run_stopped(input string name, input rate_idx_t rate, input logic loop,
		input byte_t a, input byte_t l, input int n_stop);
		start_sample(name, rate, loop, 1'b1, a, l);
		while (fetches < n_stop) begin
			@(posedge aclk);
			check_bit({name, " irq"}, 1'b0, irq);
		end
		exp_count = '0;
		write_reg(off_status, 8'h00);   // Disable mid sample
		@(posedge aclk);
		check_bit({name, " dmc_active after disable"}, 1'b0, dmc_active);
		check_len({name, " fetch count"}, len_t'(n_stop), len_t'(fetches));
		drain(name, 1'b0);
	endtask

	task automatic level_write(input string name, input level_t v);
		cur_test = name;
		if (int'(v) != model_level) begin
			exp_q.push_back(v);
			step_q.push_back(1'b0);
		end
		model_level = v;
		write_reg(off_level, {1'b0, v});
		@(posedge aclk);
		check_level({name, " dmc_out"}, v, dmc_out);
	endtask

	initial begin : memory_responder
		int delay;
		dma_ack   <= 1'b0;
		dma_rdata <= '0;
		forever begin
			@(posedge aclk);
			if (!rst && dma_req) begin
				delay = 1 + int'(rand_bits(3));
				repeat (delay - 1) @(posedge aclk);
				check_bit({cur_test, " dma_req held"}, 1'b1, dma_req);
				check_addr({cur_test, " dma_addr"}, exp_addr, dma_addr);
				play_byte(mem_byte(exp_addr));
				fetches++;
				if (exp_count != '0) begin
					exp_count--;
					if (exp_count == '0 && exp_loop) begin
						exp_addr  = loop_addr;
						exp_count = loop_len;
					end else begin
						exp_addr = (exp_addr == 16'hFFFF) ? addr_t'(`DMC_ADDR_WRAP) : exp_addr + 16'd1;
					end
				end
				dma_ack   <= 1'b1;
				dma_rdata <= mem_byte(dma_addr);
				@(posedge aclk);
				dma_ack <= 1'b0;
			end
		end
	end

	initial begin : level_monitor
		level_t prev;
		bit     is_step;
		prev = '0;
		forever begin
			@(posedge aclk);
			cyc++;
			if (!rst && dmc_out !== prev) begin
				if (exp_q.size() == 0)
					report_fail($sformatf("%s: dmc_out moved to %0d with no change predicted",
						cur_test, dmc_out));
				is_step = step_q.pop_front();
				check_level({cur_test, " dmc_out"}, exp_q.pop_front(), dmc_out);
				if (is_step) begin
					if (last_step_cyc >= 0 && (cyc - last_step_cyc) % space_period != 0)
						report_fail($sformatf("%s: level change off the %0d cycle bit grid",
							cur_test, space_period));
					last_step_cyc = cyc;
				end
				prev = dmc_out;
			end
		end
	end

	initial begin : watchdog
		repeat (wd_cycles) @(posedge aclk);
		report_fail("Timeout: the tests did not finish in the allowed time");
	end

	initial begin : stimulus
		rst       <= 1'b1;
		reg_wr    <= 1'b0;
		reg_addr  <= off_ctrl;
		reg_wdata <= '0;
		repeat (16) @(posedge aclk);
		rst <= 1'b0;
		@(posedge aclk);
		check_bit("reset dma_req", 1'b0, dma_req);
		check_bit("reset irq", 1'b0, irq);
		check_bit("reset dmc_active", 1'b0, dmc_active);
		check_level("reset dmc_out", '0, dmc_out);

		run_sample("single", rate_idx_t'(rand_bits(4)), 1'b1, byte_t'(rand_bits(8)),
			byte_t'(rand_bits(1)));
		repeat (3)
			level_write("level_write", level_t'(rand_bits(7)));
		level_write("level_high", 7'h78);
		run_sample("wrap", 4'hF, 1'b0, 8'hFF, 8'h04);   // FFC0 up through 8000
		run_stopped("loop", rate_idx_t'(rand_bits(4)), 1'b1, byte_t'(rand_bits(8)), 8'h01, 40);
		run_stopped("stop", rate_idx_t'(rand_bits(4)), 1'b0, byte_t'(rand_bits(8)), 8'h02, 5);
		level_write("level_last", level_t'(rand_bits(7)));

		$display("NO ERRORS");
		$finish;
	end

endmodule

//--- dmc_channel.f
+incdir+.
dmc_pkg.sv
dmc_reg_if.sv
dmc_sample_if.sv
dmc_regs.sv
dmc_fetch.sv
dmc_sample_buffer.sv
dmc_output.sv
dmc_channel.sv
tb_dmc_channel.sv

//--- Bender.yml
package:
  name: dmc_channel

export_include_dirs:
  - .

sources:
  - files:
      - dmc_pkg.sv
      - dmc_reg_if.sv
      - dmc_sample_if.sv
      - dmc_regs.sv
      - dmc_fetch.sv
      - dmc_sample_buffer.sv
      - dmc_output.sv
      - dmc_channel.sv
  - target: test
    files:
      - tb_dmc_channel.sv
